// ==== dupBusInterface.sv ====
// Wishbone classic, word wide; master must hold cyc/stb until ack, one wait state per access
module dupBusInterface import dupPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    wbCyc,
   input  logic                    wbStb,
   input  logic                    wbWe,
   input  logic [RegAddrWidth-1:0] wbAdr,
   input  logic [RegWidth-1:0]     wbDatW,
   output logic [RegWidth-1:0]     wbDatR,
   output logic                    wbAck,
   input  rxStatusT                rxStatus,
   input  txStatusT                txStatus,
   output regAccessT               regAccess,
   output logic                    irq
);

   logic     access;
   logic     rxCsrWrite;
   logic     rxDbufRead;
   logic     txCsrWrite;
   logic     txDbufWrite;
   ctrlWordT wdata;

   ////////////////////////////////////////////////////////////
   // Decode and acknowledge
   ////////////////////////////////////////////////////////////

   assign access = wbCyc & wbStb & ~wbAck;   // New request this cycle

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wbAck       <= 1'b0;
         rxCsrWrite  <= 1'b0;
         rxDbufRead  <= 1'b0;
         txCsrWrite  <= 1'b0;
         txDbufWrite <= 1'b0;
      end
      else
      begin
         wbAck       <= access;              // Unmapped offsets ack too
         rxCsrWrite  <= access &  wbWe & (wbAdr == RxCsrAddr);
         rxDbufRead  <= access & ~wbWe & (wbAdr == RxDbufAddr);
         txCsrWrite  <= access &  wbWe & (wbAdr == TxCsrAddr);
         txDbufWrite <= access &  wbWe & (wbAdr == TxDbufAddr);
      end
   end

   always_ff @(posedge clk)
   begin
      if (access && wbWe)
         wdata <= wbDatW;
   end

   always_comb
   begin
      regAccess.wdata       = wdata;
      regAccess.rxCsrWrite  = rxCsrWrite;
      regAccess.rxDbufRead  = rxDbufRead;
      regAccess.txCsrWrite  = txCsrWrite;
      regAccess.txDbufWrite = txDbufWrite;
   end

   ////////////////////////////////////////////////////////////
   // Read data and interrupt
   ////////////////////////////////////////////////////////////

   // Address is still held while ack is up
   always_comb
   begin
      wbDatR = '0;
      case (wbAdr)
         RxCsrAddr:
         begin
            wbDatR           = rxStatus.csr;
            wbDatR[RxActBit] = rxStatus.rxActive;
         end
         RxDbufAddr: wbDatR = rxStatus.dbuf;
         TxCsrAddr:  wbDatR = txStatus.csr;
         TxDbufAddr: wbDatR = txStatus.dbuf;
         VectorAddr: wbDatR = rxStatus.rxIrq ? RxVector : TxVector;   // Receiver first
         default:    wbDatR = '0;
      endcase
   end

   assign irq = rxStatus.rxIrq | txStatus.txIrq;

   assert property (@(posedge clk) disable iff (reset)
      wbAck |=> !wbAck)
      else $error("wbAck held for two cycles");

endmodule

// ==== dupPatterns.txt ====
# cmd addr value mask: W write value, R masked read must equal value, P poll masked read
# S send value on rxd after two sync chars, I irq must equal value, = names the next test
= resetAndRegisters
R 2 0080 FFFF
R 0 0000 FFFF
I 0 0000 0000
W 0 0090 0000
R 0 0010 FFFF
W 2 0010 0000
R 2 0090 FFFF
W 2 0000 0000
R 2 0080 FFFF
W 0 0000 0000
= loopback
W 2 1010 0000
W 0 0010 0000
P 0 0800 0800
R 0 0000 0080
W 3 005A 0000
P 0 0080 0080
R 1 005A FFFF
R 3 005A FFFF
= externalReceive
W 2 0000 0000
W 0 0000 0000
W 0 0010 0000
S 0 00A3 0000
P 0 0080 0080
R 1 00A3 FFFF
R 0 0000 0080
= interrupts
W 0 0050 0000
S 0 random 0000
P 0 0080 0080
I 0 0001 0000
R 4 00C0 FFFF
R 1 random FFFF
W 2 0040 0000
I 0 0001 0000
R 4 00C4 FFFF
W 2 0000 0000
W 0 0000 0000
I 0 0000 0000
= unmapped
R 6 0000 FFFF
W 6 FFFF 0000
R 0 0000 FFFF

// ==== dupPkg.sv ====
// Word access only with no byte lanes; one bit divider shared by transmitter and loopback receive
package dupPkg;

   ////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////

   localparam int RegAddrWidth = 3;
   localparam int RegWidth     = 16;

   localparam logic [RegAddrWidth-1:0] RxCsrAddr  = 3'd0;
   localparam logic [RegAddrWidth-1:0] RxDbufAddr = 3'd1;
   localparam logic [RegAddrWidth-1:0] TxCsrAddr  = 3'd2;
   localparam logic [RegAddrWidth-1:0] TxDbufAddr = 3'd3;
   localparam logic [RegAddrWidth-1:0] VectorAddr = 3'd4;  // Interrupt vector, read only

   // RXCSR fields
   localparam int RxEnBit   = 4;
   localparam int RxIeBit   = 6;
   localparam int RxDoneBit = 7;
   localparam int RxActBit  = 11;

   // TXCSR fields
   localparam int SendBit   = 4;
   localparam int TxIeBit   = 6;
   localparam int TxDoneBit = 7;
   localparam int MaintBit  = 12;

   ////////////////////////////////////////////////////////////
   // Line constants
   ////////////////////////////////////////////////////////////

   localparam int CharWidth  = 8;
   localparam int CountWidth = $clog2(CharWidth);
   localparam logic [CharWidth-1:0] SyncChar = 8'h96;   // Also the idle fill

   localparam int BitDivide = 8;                         // Clocks per line bit
   localparam int DivWidth  = $clog2(BitDivide);

   localparam logic [RegWidth-1:0] RxVector = 16'h00C0;
   localparam logic [RegWidth-1:0] TxVector = 16'h00C4;

   ////////////////////////////////////////////////////////////
   // Shared types
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [3:0] rsvdHi;
      logic       rxAct;
      logic [2:0] rsvdMid;
      logic       rxDone;
      logic       rxIe;
      logic       rsvd5;
      logic       rxEn;
      logic [3:0] rsvdLo;
   } rxViewT;

   typedef struct packed {
      logic [2:0] rsvdHi;
      logic       maint;
      logic [3:0] rsvdMid;
      logic       txDone;
      logic       txIe;
      logic       rsvd5;
      logic       send;
      logic [3:0] rsvdLo;
   } txViewT;

   // Same write word, seen by whichever CSR is addressed
   typedef union packed {
      rxViewT rxView;
      txViewT txView;
   } ctrlWordT;

   typedef struct packed {
      ctrlWordT wdata;
      logic     rxCsrWrite;
      logic     rxDbufRead;
      logic     txCsrWrite;
      logic     txDbufWrite;
   } regAccessT;

   typedef struct packed {
      logic [RegWidth-1:0] csr;
      logic [RegWidth-1:0] dbuf;
      logic                rxIrq;    // RXIE and RXDONE
      logic                rxActive;
   } rxStatusT;

   typedef struct packed {
      logic [RegWidth-1:0] csr;
      logic [RegWidth-1:0] dbuf;
      logic                txIrq;    // TXIE and TXDONE
   } txStatusT;

endpackage

// ==== dupReceiver.sv ====
// External rxc must be much slower than clk; a character arriving before RXDBUF is read replaces it
module dupReceiver import dupPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  regAccessT regAccess,
   input  logic      maint,
   input  logic      bitTick,
   input  logic      loopTxd,
   input  logic      rxc,
   input  logic      rxd,
   output rxStatusT  rxStatus
);

   logic                  rxEn;
   logic                  rxIe;
   logic                  rxAct;
   logic                  rxDone;
   logic [CharWidth-1:0]  rxBuf;
   logic [2:0]            rxcSync;        // Two sync stages plus edge history
   logic [1:0]            rxdSync;
   logic                  sampleEn;
   logic                  sampleBit;
   logic [CharWidth-1:0]  window;
   logic [CharWidth-1:0]  nextWindow;
   logic [CountWidth-1:0] bitCount;
   logic                  charDone;
   logic                  newChar;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxEn <= 1'b0;
         rxIe <= 1'b0;
      end
      else if (regAccess.rxCsrWrite)
      begin
         rxEn <= regAccess.wdata.rxView.rxEn;
         rxIe <= regAccess.wdata.rxView.rxIe;
      end
   end

   ////////////////////////////////////////////////////////////
   // Sample source
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      rxcSync <= {rxcSync[1:0], rxc};
      rxdSync <= {rxdSync[0], rxd};
   end

   // Loopback takes txd at the end of each transmit bit
   assign sampleEn   = maint ? bitTick : (rxcSync[1] & ~rxcSync[2]);
   assign sampleBit  = maint ? loopTxd : rxdSync[1];
   assign nextWindow = {sampleBit, window[CharWidth-1:1]};   // LSB arrives first

   always_ff @(posedge clk)
   begin
      if (!rxEn)
         window <= '0;
      else if (sampleEn)
         window <= nextWindow;
   end

   ////////////////////////////////////////////////////////////
   // Sync search and character assembly
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || !rxEn)
      begin
         rxAct    <= 1'b0;                // Disable drops sync
         bitCount <= '0;
      end
      else if (sampleEn)
      begin
         if (!rxAct)
         begin
            rxAct    <= (nextWindow == SyncChar);
            bitCount <= '0;
         end
         else
            bitCount <= bitCount + 1'b1;
      end
   end

   assign charDone = rxEn & rxAct & sampleEn & (bitCount == '1);
   assign newChar  = charDone & (nextWindow != SyncChar);   // Fill is dropped

   always_ff @(posedge clk)
   begin
      if (reset)
         rxDone <= 1'b0;
      else if (newChar)
         rxDone <= 1'b1;
      else if (regAccess.rxDbufRead)
         rxDone <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (newChar)
         rxBuf <= nextWindow;             // Overruns silently
   end

   // Sync flag travels separately as rxActive
   always_comb
   begin
      rxStatus                = '0;
      rxStatus.csr[RxEnBit]   = rxEn;
      rxStatus.csr[RxIeBit]   = rxIe;
      rxStatus.csr[RxDoneBit] = rxDone;
      rxStatus.dbuf           = RegWidth'(rxBuf);
      rxStatus.rxIrq          = rxIe & rxDone;
      rxStatus.rxActive       = rxAct;
   end

   assert property (@(posedge clk) disable iff (reset)
      $rose(rxDone) |-> $past(rxAct))
      else $error("RXDONE set without receiver sync");

endmodule

// ==== dupTop.sv ====
// Single clock domain; rxc and rxd are asynchronous and resynchronized inside the receiver
module dupTop import dupPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    wbCyc,
   input  logic                    wbStb,
   input  logic                    wbWe,
   input  logic [RegAddrWidth-1:0] wbAdr,
   input  logic [RegWidth-1:0]     wbDatW,
   output logic [RegWidth-1:0]     wbDatR,
   output logic                    wbAck,
   output logic                    irq,
   input  logic                    rxc,
   input  logic                    rxd,
   output logic                    txd
);

   regAccessT regAccess;
   rxStatusT  rxStatus;
   txStatusT  txStatus;
   logic      bitTick;

   ////////////////////////////////////////////////////////////
   // Host side
   ////////////////////////////////////////////////////////////

   dupBusInterface uBus (
      .clk       (clk),
      .reset     (reset),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbDatW    (wbDatW),
      .wbDatR    (wbDatR),
      .wbAck     (wbAck),
      .rxStatus  (rxStatus),
      .txStatus  (txStatus),
      .regAccess (regAccess),
      .irq       (irq)
   );

   // Line side, loopback driven by TXCSR maint bit
   dupReceiver uRx (
      .clk       (clk),
      .reset     (reset),
      .regAccess (regAccess),
      .maint     (txStatus.csr[MaintBit]),
      .bitTick   (bitTick),
      .loopTxd   (txd),
      .rxc       (rxc),
      .rxd       (rxd),
      .rxStatus  (rxStatus)
   );

   dupTransmitter uTx (
      .clk       (clk),
      .reset     (reset),
      .regAccess (regAccess),
      .txStatus  (txStatus),
      .bitTick   (bitTick),
      .txd       (txd)
   );

endmodule

// ==== dupTransmitter.sv ====
// Sends LSB first with a fixed divider; fills with the sync character whenever TXDBUF is empty
module dupTransmitter import dupPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  regAccessT regAccess,
   output txStatusT  txStatus,
   output logic      bitTick,
   output logic      txd
);

   logic                  send;
   logic                  txIe;
   logic                  maint;
   logic                  txDone;
   logic [CharWidth-1:0]  txBuf;
   logic [DivWidth-1:0]   divCount;
   logic [CharWidth-1:0]  shifter;
   logic [CountWidth-1:0] bitCount;
   logic                  loadChar;
   logic [CharWidth-1:0]  nextChar;

   ////////////////////////////////////////////////////////////
   // Control bits and data buffer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         send  <= 1'b0;
         txIe  <= 1'b0;
         maint <= 1'b0;
      end
      else if (regAccess.txCsrWrite)
      begin
         send  <= regAccess.wdata.txView.send;
         txIe  <= regAccess.wdata.txView.txIe;
         maint <= regAccess.wdata.txView.maint;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         txDone <= 1'b1;
      else if (regAccess.txDbufWrite)
         txDone <= 1'b0;                  // Buffer full again
      else if (loadChar)
         txDone <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (regAccess.txDbufWrite)
         txBuf <= regAccess.wdata[CharWidth-1:0];
   end

   // Bit rate divider
   always_ff @(posedge clk)
   begin
      if (reset || bitTick)
         divCount <= '0;
      else
         divCount <= divCount + 1'b1;
   end

   assign bitTick  = (divCount == DivWidth'(BitDivide - 1));
   assign loadChar = send & bitTick & (bitCount == '0);
   assign nextChar = txDone ? SyncChar : txBuf;   // Nothing queued so send fill

   ////////////////////////////////////////////////////////////
   // Shifter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || !send)
      begin
         txd      <= 1'b1;                // Idle mark
         bitCount <= '0;
      end
      else if (bitTick)
      begin
         txd      <= loadChar ? nextChar[0] : shifter[0];
         bitCount <= bitCount - 1'b1;     // Wraps to 7 on load
      end
   end

   always_ff @(posedge clk)
   begin
      if (loadChar)
         shifter <= {1'b0, nextChar[CharWidth-1:1]};
      else if (bitTick)
         shifter <= {1'b0, shifter[CharWidth-1:1]};
   end

   always_comb
   begin
      txStatus                = '0;
      txStatus.csr[SendBit]   = send;
      txStatus.csr[TxIeBit]   = txIe;
      txStatus.csr[TxDoneBit] = txDone;
      txStatus.csr[MaintBit]  = maint;
      txStatus.dbuf           = RegWidth'(txBuf);
      txStatus.txIrq          = txIe & txDone;
   end

   // A host write racing a load must leave the buffer marked full
   assert property (@(posedge clk) disable iff (reset)
      (regAccess.txDbufWrite && loadChar) |=> !txDone)
      else $error("TXDBUF write lost against character load");

endmodule

// ==== runSim.sh ====
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module tbDup -o simDup

./obj_dir/simDup | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
echo "Run passed"
exit 0

// ==== sources.f ====
dupPkg.sv
dupTransmitter.sv
dupReceiver.sv
dupBusInterface.sv
dupTop.sv
tbDup.sv

// ==== tbDup.sv ====
// Run from the project root so dupPatterns.txt is found; the cycle limit follows the pattern count
module tbDup;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int         ClkPeriod   = 10;
   localparam int         MaxPolls    = 400;
   localparam int         RxcHalf     = 4;        // Clocks per rxc phase
   localparam logic [7:0] SyncByte    = 8'h96;
   localparam logic [2:0] TxCsrOffset = 3'd2;
   localparam int         SendPos     = 4;        // TXCSR send enable

   logic        clk;
   logic        reset;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [2:0]  wbAdr;
   logic [15:0] wbDatW;
   logic [15:0] wbDatR;
   logic        wbAck;
   logic        irq;
   logic        rxc;
   logic        rxd;
   logic        txd;

   // One entry per pattern line
   byte         cmdQ[$];
   logic [2:0]  addrQ[$];
   logic [15:0] valueQ[$];
   logic [15:0] maskQ[$];
   bit          randQ[$];
   string       nameQ[$];

   int          commandCount = 0;
   int          errorCount   = 0;
   int          groupErrors  = 0;
   int          testCount    = 0;
   int          cycleCount   = 0;
   int          cycleLimit   = 0;
   integer      seed         = 32'he740af69;
   logic [7:0]  randByte     = 8'h00;

   dupTop u_dupTop (
      .clk    (clk),
      .reset  (reset),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .wbDatR (wbDatR),
      .wbAck  (wbAck),
      .irq    (irq),
      .rxc    (rxc),
      .rxd    (rxd),
      .txd    (txd)
   );

   initial
   begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleLimit > 0 && cycleCount >= cycleLimit)
      begin
         $display("Timeout after %0d cycles, the pattern run did not finish", cycleCount);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checking and bus access
   ////////////////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] got);
      if (got !== expected)
      begin
         $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, got);
         errorCount++;
         groupErrors++;
      end
   endtask

   function automatic string regName(input logic [2:0] addr);
      case (addr)
         3'd0:    return "RXCSR";
         3'd1:    return "RXDBUF";
         3'd2:    return "TXCSR";
         3'd3:    return "TXDBUF";
         3'd4:    return "VECTOR";
         default: return $sformatf("offset%0d", addr);
      endcase
   endfunction

   task automatic busWrite(input logic [2:0] addr, input logic [15:0] data);
      @(negedge clk);
      wbCyc  = 1'b1;
      wbStb  = 1'b1;
      wbWe   = 1'b1;
      wbAdr  = addr;
      wbDatW = data;
      do
         @(negedge clk);
      while (!wbAck);
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
   endtask

   task automatic busRead(input logic [2:0] addr, output logic [15:0] data);
      @(negedge clk);
      wbCyc = 1'b1;
      wbStb = 1'b1;
      wbWe  = 1'b0;
      wbAdr = addr;
      do
         @(negedge clk);
      while (!wbAck);
      data  = wbDatR;                           // Valid while ack is up
      wbCyc = 1'b0;
      wbStb = 1'b0;
   endtask

   task automatic pollMasked(input logic [2:0] addr, input logic [15:0] value,
                             input logic [15:0] mask);
      logic [15:0] data;
      int          reads;
      reads = 0;
      data  = '0;
      do
      begin
         busRead(addr, data);
         reads++;
      end
      while (((data & mask) !== value) && (reads < MaxPolls));
      if ((data & mask) !== value)
      begin
         $display("Poll of %s gave up after %0d reads without reaching %h under mask %h",
                  regName(addr), reads, value, mask);
         errorCount++;
         groupErrors++;
      end
   endtask

   // Send clear lands one clock after the ack, the line register one more
   task automatic checkIdleLine();
      repeat (2) @(negedge clk);
      checkValue("txd", 16'h0001, {15'd0, txd});
   endtask

   ////////////////////////////////////////////////////////////
   // Serial line driving
   ////////////////////////////////////////////////////////////

   task automatic sendBit(input logic value);
      @(negedge clk);
      rxd = value;
      rxc = 1'b0;
      repeat (RxcHalf) @(negedge clk);
      rxc = 1'b1;                               // Receiver samples on this edge
      repeat (RxcHalf - 1) @(negedge clk);
   endtask

   task automatic sendChar(input logic [7:0] ch);
      for (int i = 0; i < 8; i++)
         sendBit(ch[i]);                        // LSB first
   endtask

   task automatic sendFramed(input logic [7:0] ch);
      sendChar(SyncByte);
      sendChar(SyncByte);
      sendChar(ch);
      @(negedge clk);
      rxc = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Pattern file
   ////////////////////////////////////////////////////////////

   function automatic bit loadPatterns();
      int          fd;
      int          n;
      string       line;
      string       cmdStr;
      string       valStr;
      string       nameStr;
      logic [2:0]  addr;
      logic [15:0] value;
      logic [15:0] mask;
      fd = $fopen("dupPatterns.txt", "r");
      if (fd == 0)
         return 1'b0;
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         cmdStr = "";
         if (n > 0)
            n = $sscanf(line, "%s", cmdStr);
         if (n >= 1 && cmdStr != "" && cmdStr[0] != "#")
         begin
            value = '0;
            if (cmdStr == "=")
            begin
               n = $sscanf(line, "%s %s", cmdStr, nameStr);
               cmdQ.push_back(cmdStr[0]);
               addrQ.push_back(3'd0);
               valueQ.push_back(16'h0000);
               maskQ.push_back(16'h0000);
               randQ.push_back(1'b0);
               nameQ.push_back(nameStr);
            end
            else
            begin
               n = $sscanf(line, "%s %h %s %h", cmdStr, addr, valStr, mask);
               if (n != 4)
               begin
                  $display("Malformed pattern line: %s", line);
                  errorCount++;
               end
               if (valStr != "random")
                  n = $sscanf(valStr, "%h", value);
               cmdQ.push_back(cmdStr[0]);
               addrQ.push_back(addr);
               valueQ.push_back(value);
               maskQ.push_back(mask);
               randQ.push_back(valStr == "random");
               nameQ.push_back("");
               commandCount++;
            end
         end
      end
      $fclose(fd);
      return commandCount > 0;
   endfunction

   task automatic reportGroup(input string name);
      testCount++;
      if (groupErrors == 0)
         $display("Test %0d %s: ok", testCount, name);
      else
         $display("Test %0d %s: %0d errors", testCount, name, groupErrors);
      groupErrors = 0;
   endtask

   task automatic runPatterns();
      logic [15:0] data;
      logic [15:0] value;
      logic [31:0] randWord;
      string       current;
      int          i;
      current = "";
      data    = '0;
      for (i = 0; i < cmdQ.size(); i++)
      begin
         if (cmdQ[i] == "S" && randQ[i])
         begin
            do
            begin
               randWord = $random(seed);
               randByte = randWord[7:0];
            end
            while (randByte == SyncByte);       // Fill would never be delivered
         end
         value = randQ[i] ? {8'h00, randByte} : valueQ[i];
         case (cmdQ[i])
            "=":
            begin
               if (current != "")
                  reportGroup(current);
               current = nameQ[i];
            end
            "W":
            begin
               busWrite(addrQ[i], value);
               if (addrQ[i] == TxCsrOffset && !value[SendPos])
                  checkIdleLine();
            end
            "R":
            begin
               busRead(addrQ[i], data);
               checkValue($sformatf("wbDatR(%s)", regName(addrQ[i])), value,
                          data & maskQ[i]);
            end
            "P": pollMasked(addrQ[i], value, maskQ[i]);
            "S": sendFramed(value[7:0]);
            "I":
            begin
               @(negedge clk);
               checkValue("irq", value, {15'd0, irq});
            end
            default:
            begin
               $display("Unknown pattern command at entry %0d", i);
               errorCount++;
               groupErrors++;
            end
         endcase
      end
      if (current != "")
         reportGroup(current);
   endtask

   initial
   begin
      reset  = 1'b1;
      wbCyc  = 1'b0;
      wbStb  = 1'b0;
      wbWe   = 1'b0;
      wbAdr  = 3'd0;
      wbDatW = 16'h0000;
      rxc    = 1'b0;
      rxd    = 1'b1;
      if (!loadPatterns())
      begin
         $display("Pattern file dupPatterns.txt missing or without commands");
         $display("Simulation failed");
         $finish;
      end
      else
      begin
         cycleLimit = commandCount * MaxPolls * 3 + 1000;
         repeat (4) @(posedge clk);
         @(negedge clk);
         reset = 1'b0;
         checkIdleLine();                        // Mark after reset
         runPatterns();
         $display("Tests %0d, errors %0d", testCount, errorCount);
         if (errorCount == 0)
            $display("Simulation passed");
         else
            $display("Simulation failed");
         $finish;
      end
   end

endmodule
